// ==== common/dcache_defs.svh ====
/* Geometry macros for the two-way data cache
   Address width, block, set, tag and words per block */

`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Address and data width in bits
`define DC_ADDR_W 32

// Byte offset bits within one 32-byte block
`define DC_BLOCK_W 5

// Set index bits, 64 sets
`define DC_SET_W 6

// Tag is what is left above set and offset
`define DC_TAG_W (`DC_ADDR_W - `DC_BLOCK_W - `DC_SET_W)

// Words per block
`define DC_WORDS 8

`endif

// ==== common/dcache_pkg.sv ====
/* Shared types of the data cache
   Vector typedefs, request and tag structs, controller states */

`include "dcache_defs.svh"

package dcache_pkg;

   typedef logic [`DC_ADDR_W-1:0] word_t;
   typedef logic [`DC_ADDR_W-1:0] addr_t;
   typedef logic [`DC_TAG_W-1:0]  tag_t;
   typedef logic [`DC_SET_W-1:0]  set_idx_t;
   // Word position inside a block
   typedef logic [2:0]            word_idx_t;
   typedef logic [3:0]            bsel_t;
   // One-hot, bit 0 is way 0
   typedef logic [1:0]            way_sel_t;

   // CPU request, held by the CPU until the ack pulse
   typedef struct packed {
      logic  write;
      addr_t addr;
      word_t wdata;
      bsel_t bsel;
   } cpu_req_t;

   typedef struct packed {
      logic valid;
      tag_t tag;
   } tag_entry_t;

   // Tag store result, valid one cycle after the index
   typedef struct packed {
      way_sel_t hit_way;
      way_sel_t victim;
      logic     hit;
   } lookup_t;

   typedef enum logic [2:0] {IDLE, LOOKUP, WRITE, REFILL, INVALIDATE} dc_state_e;

endpackage

// ==== hdl/dc_tag_store.sv ====
/* Tag store with valid and tag per way, LRU bit per set,
   hit compare and victim choice */

`include "dcache_defs.svh"

module dc_tag_store (
   input  logic                 clk,
   input  dcache_pkg::set_idx_t tag_idx_i,
   input  dcache_pkg::tag_t     req_tag_i,
   input  logic                 tag_we_i,
   input  logic                 fill_done_i,
   input  logic                 inv_i,
   input  logic                 lru_touch_i,
   input  dcache_pkg::way_sel_t access_i,
   output dcache_pkg::lookup_t  lookup_o
);

   localparam int unsigned SETS = 1 << `DC_SET_W;

   dcache_pkg::tag_entry_t wr_entry;
   dcache_pkg::way_sel_t   hit_way;
   logic                   lru_mem [SETS];
   logic                   lru_we;
   logic                   lru_d;
   // Set when way 1 was used last
   logic                   rd_mru;

   // Invalidate clears valid, fill sets it with the request tag
   always_comb begin
      wr_entry.valid = ~inv_i;
      wr_entry.tag   = req_tag_i;
   end

   for (genvar w = 0; w < 2; w++) begin : g_way
      dcache_pkg::tag_entry_t mem [SETS];
      dcache_pkg::tag_entry_t rd_entry;
      logic                   we;

      assign we = tag_we_i & (inv_i | (fill_done_i & access_i[w]));

      // Same index write is passed to the read port
      always_ff @(posedge clk) begin
         if (we) begin
            mem[tag_idx_i] <= wr_entry;
            rd_entry       <= wr_entry;
         end else begin
            rd_entry <= mem[tag_idx_i];
         end
      end

      assign hit_way[w] = rd_entry.valid & (rd_entry.tag == req_tag_i);
   end

   // Invalidate also resets the LRU bit
   assign lru_we = tag_we_i & (inv_i | lru_touch_i);
   assign lru_d  = ~inv_i & access_i[1];

   always_ff @(posedge clk) begin
      if (lru_we) begin
         lru_mem[tag_idx_i] <= lru_d;
         rd_mru             <= lru_d;
      end else begin
         rd_mru <= lru_mem[tag_idx_i];
      end
   end

   assign lookup_o.hit_way = hit_way;
   assign lookup_o.hit     = |hit_way;
   // Replace the way not used last
   assign lookup_o.victim  = rd_mru ? 2'b01 : 2'b10;

   // Refill only writes a tag that missed in both ways
   assert property (@(posedge clk) disable iff ($isunknown(hit_way)) $onehot0(hit_way))
      else $error("dc_tag_store: both ways hit");

endmodule

// ==== hdl/dc_way_store.sv ====
/* Two data RAMs with hit-way read mux and byte-select write merge */

`include "dcache_defs.svh"

module dc_way_store (
   input  logic                  clk,
   input  dcache_pkg::addr_t     rd_adr_i,
   input  dcache_pkg::way_sel_t  way_we_i,
   input  dcache_pkg::word_idx_t way_word_i,
   input  logic                  use_fill_i,
   input  dcache_pkg::way_sel_t  hit_way_i,
   input  dcache_pkg::word_t     fill_dat_i,
   input  dcache_pkg::word_t     wr_dat_i,
   input  dcache_pkg::bsel_t     bsel_i,
   output dcache_pkg::word_t     rdata_o
);

   localparam int unsigned RA_W  = `DC_SET_W + `DC_BLOCK_W - 2;
   localparam int unsigned WORDS = 1 << RA_W;

   logic [RA_W-1:0]         rd_wadr;
   logic [RA_W-1:0]         wr_wadr;
   dcache_pkg::word_t       merge_dat;
   dcache_pkg::word_t       wr_word;
   dcache_pkg::word_t [1:0] way_dout;

   assign rd_wadr = rd_adr_i[RA_W+1:2];
   // Write goes to the same set, word from the controller
   assign wr_wadr = {rd_adr_i[RA_W+1:`DC_BLOCK_W], way_word_i};

   // CPU bytes over the stored word
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merge_dat[8*b +: 8] = bsel_i[b] ? wr_dat_i[8*b +: 8] : rdata_o[8*b +: 8];
      end
      wr_word = use_fill_i ? fill_dat_i : merge_dat;
   end

   for (genvar w = 0; w < 2; w++) begin : g_ram
      dcache_pkg::word_t mem [WORDS];
      dcache_pkg::word_t dout;

      always_ff @(posedge clk) begin
         if (way_we_i[w]) begin
            mem[wr_wadr] <= wr_word;
         end
         // Last refill word may be the one being read
         if (way_we_i[w] && wr_wadr == rd_wadr) begin
            dout <= wr_word;
         end else begin
            dout <= mem[rd_wadr];
         end
      end

      assign way_dout[w] = dout;
   end

   assign rdata_o = hit_way_i[1] ? way_dout[1] : way_dout[0];

endmodule

// ==== hdl/dcache_ctrl.sv ====
/* Cache controller FSM with held request, refill counter,
   pending invalidate and the tag clear walk after reset */

`include "dcache_defs.svh"

module dcache_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  cpu_req_valid_i,
   input  dcache_pkg::cpu_req_t  cpu_req_i,
   output logic                  cpu_ack_o,
   output logic                  refill_req_o,
   output dcache_pkg::addr_t     refill_adr_o,
   input  logic                  mem_valid_i,
   input  logic                  inv_i,
   input  dcache_pkg::set_idx_t  inv_idx_i,
   output logic                  inv_ack_o,
   input  dcache_pkg::lookup_t   lookup_i,
   output dcache_pkg::set_idx_t  tag_idx_o,
   output logic                  tag_we_o,
   output logic                  fill_done_o,
   output logic                  inv_o,
   output logic                  lru_touch_o,
   output dcache_pkg::way_sel_t  access_o,
   output dcache_pkg::way_sel_t  way_we_o,
   output dcache_pkg::word_idx_t way_word_o,
   output logic                  use_fill_o
);

   localparam int FILL_W = $clog2(`DC_WORDS) + 1;

   dcache_pkg::dc_state_e state;
   dcache_pkg::dc_state_e state_nxt;
   dcache_pkg::cpu_req_t  req_q;
   dcache_pkg::way_sel_t  victim_q;
   dcache_pkg::set_idx_t  inv_idx_q;
   dcache_pkg::set_idx_t  clr_idx;
   dcache_pkg::set_idx_t  req_idx;
   dcache_pkg::word_idx_t req_word;
   logic                  clr_busy;
   logic                  inv_pend;
   logic                  fill_last;
   logic [FILL_W-1:0]     fill_cnt;

   assign req_idx      = req_q.addr[`DC_BLOCK_W+`DC_SET_W-1:`DC_BLOCK_W];
   assign req_word     = req_q.addr[`DC_BLOCK_W-1:2];
   assign refill_adr_o = {req_q.addr[`DC_ADDR_W-1:`DC_BLOCK_W], {`DC_BLOCK_W{1'b0}}};
   // Last word of the block is on the bus
   assign fill_last    = mem_valid_i && (fill_cnt == FILL_W'(`DC_WORDS - 1));

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= dcache_pkg::IDLE;
         clr_busy <= 1'b1;
         clr_idx  <= '0;
         inv_pend <= 1'b0;
         fill_cnt <= '0;
      end else begin
         state <= state_nxt;
         // Walk every set once to clear the tag RAM
         if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (&clr_idx) begin
               clr_busy <= 1'b0;
            end
         end
         if (state == dcache_pkg::INVALIDATE) begin
            inv_pend <= 1'b0;
         end
         // A new strobe wins over the clear
         if (inv_i) begin
            inv_pend <= 1'b1;
         end
         if (state == dcache_pkg::LOOKUP) begin
            fill_cnt <= '0;
         end else if (state == dcache_pkg::REFILL && mem_valid_i) begin
            fill_cnt <= fill_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == dcache_pkg::IDLE) begin
         req_q <= cpu_req_i;
      end
      // Victim is fixed at the miss
      if (state == dcache_pkg::LOOKUP && !lookup_i.hit) begin
         victim_q <= lookup_i.victim;
      end
      if (inv_i) begin
         inv_idx_q <= inv_idx_i;
      end
   end

   always_comb begin
      state_nxt    = state;
      cpu_ack_o    = 1'b0;
      refill_req_o = 1'b0;
      inv_ack_o    = 1'b0;
      tag_idx_o    = req_idx;
      tag_we_o     = 1'b0;
      fill_done_o  = 1'b0;
      inv_o        = 1'b0;
      lru_touch_o  = 1'b0;
      access_o     = lookup_i.hit_way;
      way_we_o     = '0;
      way_word_o   = req_word;
      use_fill_o   = 1'b0;
      case (state)
         dcache_pkg::IDLE: begin
            // Read the set of the incoming request so LOOKUP has it
            tag_idx_o = cpu_req_i.addr[`DC_BLOCK_W+`DC_SET_W-1:`DC_BLOCK_W];
            if (clr_busy) begin
               tag_idx_o = clr_idx;
               tag_we_o  = 1'b1;
               inv_o     = 1'b1;
            end else if (inv_i || inv_pend) begin
               state_nxt = dcache_pkg::INVALIDATE;
            end else if (cpu_req_valid_i) begin
               state_nxt = dcache_pkg::LOOKUP;
            end
         end
         dcache_pkg::LOOKUP: begin
            if (lookup_i.hit && req_q.write) begin
               state_nxt = dcache_pkg::WRITE;
            end else if (lookup_i.hit) begin
               cpu_ack_o   = 1'b1;
               tag_we_o    = 1'b1;
               lru_touch_o = 1'b1;
               state_nxt   = dcache_pkg::IDLE;
            end else if (req_q.write) begin
               // Write miss goes to memory outside the cache
               cpu_ack_o = 1'b1;
               state_nxt = dcache_pkg::IDLE;
            end else begin
               state_nxt = dcache_pkg::REFILL;
            end
         end
         dcache_pkg::WRITE: begin
            way_we_o    = lookup_i.hit_way;
            tag_we_o    = 1'b1;
            lru_touch_o = 1'b1;
            cpu_ack_o   = 1'b1;
            state_nxt   = dcache_pkg::IDLE;
         end
         dcache_pkg::REFILL: begin
            refill_req_o = 1'b1;
            access_o     = victim_q;
            way_word_o   = fill_cnt[FILL_W-2:0];
            use_fill_o   = 1'b1;
            if (mem_valid_i) begin
               way_we_o = victim_q;
            end
            // Tag goes valid with the last word, then LOOKUP hits
            if (fill_last) begin
               tag_we_o    = 1'b1;
               fill_done_o = 1'b1;
               lru_touch_o = 1'b1;
               state_nxt   = dcache_pkg::LOOKUP;
            end
         end
         dcache_pkg::INVALIDATE: begin
            tag_idx_o = inv_idx_q;
            tag_we_o  = 1'b1;
            inv_o     = 1'b1;
            inv_ack_o = 1'b1;
            state_nxt = dcache_pkg::IDLE;
         end
         default: begin
            state_nxt = dcache_pkg::IDLE;
         end
      endcase
   end

   // A finished refill hits in the next LOOKUP and acks there
   assert property (@(posedge clk) disable iff (rst) $fell(refill_req_o) |-> cpu_ack_o)
      else $error("dcache_ctrl: no ack after refill");
   assert property (@(posedge clk) disable iff (rst) $onehot0(way_we_o))
      else $error("dcache_ctrl: more than one way written");
   assert property (@(posedge clk) disable iff (rst) fill_cnt <= FILL_W'(`DC_WORDS))
      else $error("dcache_ctrl: refill counter overrun");

endmodule

// ==== hdl/dcache_top.sv ====
/* Data cache top level
   Controller, tag store and way store */

`include "dcache_defs.svh"

module dcache_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cpu_req_valid_i,
   input  dcache_pkg::cpu_req_t cpu_req_i,
   output logic                 cpu_ack_o,
   output dcache_pkg::word_t    cpu_rdata_o,
   output logic                 refill_req_o,
   output dcache_pkg::addr_t    refill_adr_o,
   input  logic                 mem_valid_i,
   input  dcache_pkg::word_t    mem_dat_i,
   input  logic                 inv_i,
   input  dcache_pkg::set_idx_t inv_idx_i,
   output logic                 inv_ack_o
);

   // Controller to tag store
   dcache_pkg::lookup_t   lookup;
   dcache_pkg::set_idx_t  tag_idx;
   logic                  tag_we;
   logic                  fill_done;
   logic                  tag_inv;
   logic                  lru_touch;
   dcache_pkg::way_sel_t  access;
   // Controller to way store
   dcache_pkg::way_sel_t  way_we;
   dcache_pkg::word_idx_t way_word;
   logic                  use_fill;

   dcache_ctrl dcache_ctrl_i (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_valid_i (cpu_req_valid_i),
      .cpu_req_i       (cpu_req_i),
      .cpu_ack_o       (cpu_ack_o),
      .refill_req_o    (refill_req_o),
      .refill_adr_o    (refill_adr_o),
      .mem_valid_i     (mem_valid_i),
      .inv_i           (inv_i),
      .inv_idx_i       (inv_idx_i),
      .inv_ack_o       (inv_ack_o),
      .lookup_i        (lookup),
      .tag_idx_o       (tag_idx),
      .tag_we_o        (tag_we),
      .fill_done_o     (fill_done),
      .inv_o           (tag_inv),
      .lru_touch_o     (lru_touch),
      .access_o        (access),
      .way_we_o        (way_we),
      .way_word_o      (way_word),
      .use_fill_o      (use_fill)
   );

   // Tag is taken straight from the held CPU address
   dc_tag_store dc_tag_store_i (
      .clk         (clk),
      .tag_idx_i   (tag_idx),
      .req_tag_i   (cpu_req_i.addr[`DC_ADDR_W-1:`DC_ADDR_W-`DC_TAG_W]),
      .tag_we_i    (tag_we),
      .fill_done_i (fill_done),
      .inv_i       (tag_inv),
      .lru_touch_i (lru_touch),
      .access_i    (access),
      .lookup_o    (lookup)
   );

   dc_way_store dc_way_store_i (
      .clk        (clk),
      .rd_adr_i   (cpu_req_i.addr),
      .way_we_i   (way_we),
      .way_word_i (way_word),
      .use_fill_i (use_fill),
      .hit_way_i  (lookup.hit_way),
      .fill_dat_i (mem_dat_i),
      .wr_dat_i   (cpu_req_i.wdata),
      .bsel_i     (cpu_req_i.bsel),
      .rdata_o    (cpu_rdata_o)
   );

endmodule

// ==== verification/dcache_tb.sv ====
/* Testbench for the data cache with clock, reset, memory responder,
   golden file player, value check and cycle timeout */

`include "dcache_defs.svh"

module dcache_tb;

   localparam int RESET_CYCLES  = 16;
   localparam int CYCLES_PER_OP = 200;
   localparam int DRIVE_DELAY   = 1;
   // Bytes in one cache block
   localparam int BLOCK_BYTES   = 4 * `DC_WORDS;

   // One line of the golden file
   typedef struct packed {
      logic [7:0]        code;
      dcache_pkg::addr_t addr;
      dcache_pkg::word_t wdata;
      dcache_pkg::bsel_t bsel;
      dcache_pkg::word_t exp_data;
      logic              refill;
   } golden_op_t;

   logic                 clk;
   logic                 rst;
   logic                 cpu_req_valid;
   dcache_pkg::cpu_req_t cpu_req;
   logic                 cpu_ack;
   dcache_pkg::word_t    cpu_rdata;
   logic                 refill_req;
   dcache_pkg::addr_t    refill_adr;
   logic                 mem_valid;
   dcache_pkg::word_t    mem_dat;
   logic                 inv;
   dcache_pkg::set_idx_t inv_idx;
   logic                 inv_ack;
   golden_op_t           ops[$];
   int                   cycle_cnt;
   int                   cycle_limit;

   dcache_top dcache_top_i (
      .clk             (clk),
      .rst             (rst),
      .cpu_req_valid_i (cpu_req_valid),
      .cpu_req_i       (cpu_req),
      .cpu_ack_o       (cpu_ack),
      .cpu_rdata_o     (cpu_rdata),
      .refill_req_o    (refill_req),
      .refill_adr_o    (refill_adr),
      .mem_valid_i     (mem_valid),
      .mem_dat_i       (mem_dat),
      .inv_i           (inv),
      .inv_idx_i       (inv_idx),
      .inv_ack_o       (inv_ack)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Result: FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_value(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
      if (got !== expected) begin
         $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, expected);
         $display("Result: FAILED");
         $fatal(1, "check failed");
      end
   endtask

   // Lines starting with # are column notes
   task automatic load_golden();
      int                fd;
      int                n;
      string             text;
      logic [7:0]        code;
      logic [31:0]       adr;
      logic [31:0]       wdat;
      logic [31:0]       expd;
      logic [3:0]        bs;
      logic              rf;
      golden_op_t        op;
      fd = $fopen("verification/dcache_golden.txt", "r");
      if (fd == 0) begin
         abort_run("Cannot open the golden file verification/dcache_golden.txt");
      end
      while (!$feof(fd)) begin
         text = "";
         n = $fgets(text, fd);
         if (n > 1 && text[0] != "#") begin
            n = $sscanf(text, "%c %h %h %h %h %h", code, adr, wdat, bs, expd, rf);
            if (n != 6) begin
               abort_run($sformatf("Golden file line is malformed: %s", text));
            end
            op.code     = code;
            op.addr     = adr;
            op.wdata    = wdat;
            op.bsel     = bs;
            op.exp_data = expd;
            op.refill   = rf;
            ops.push_back(op);
         end
      end
      $fclose(fd);
   endtask

   // Read or write request held until the ack pulse
   task automatic run_request(input golden_op_t op, input int idx);
      logic              seen_refill;
      dcache_pkg::word_t rdata;
      seen_refill         = 1'b0;
      cpu_req.write       = (op.code == "W");
      cpu_req.addr        = op.addr;
      cpu_req.wdata       = op.wdata;
      cpu_req.bsel        = op.bsel;
      cpu_req_valid       = 1'b1;
      do begin
         @(negedge clk);
         if (refill_req) begin
            seen_refill = 1'b1;
            check_value(refill_adr, op.addr & ~32'(BLOCK_BYTES - 1),
                        $sformatf("entry %0d refill address", idx));
         end
      end while (!cpu_ack);
      rdata = cpu_rdata;
      @(posedge clk);
      #DRIVE_DELAY;
      cpu_req_valid = 1'b0;
      if (op.code == "R") begin
         check_value(rdata, op.exp_data, $sformatf("entry %0d read data", idx));
      end
      check_value({31'b0, seen_refill}, {31'b0, op.refill},
                  $sformatf("entry %0d refill seen", idx));
   endtask

   // Strobe for one cycle, then expect a single ack pulse
   task automatic run_invalidate(input golden_op_t op, input int idx);
      inv     = 1'b1;
      inv_idx = op.addr[`DC_SET_W-1:0];
      @(posedge clk);
      #DRIVE_DELAY;
      inv = 1'b0;
      do begin
         @(negedge clk);
      end while (!inv_ack);
      @(negedge clk);
      check_value({31'b0, inv_ack}, 32'b0, $sformatf("entry %0d inv ack length", idx));
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   // Memory returns one word every other cycle, valued by its byte address
   initial begin : mem_responder
      int word_cnt;
      word_cnt  = 0;
      mem_valid = 1'b0;
      mem_dat   = '0;
      forever begin
         @(posedge clk);
         #DRIVE_DELAY;
         if (refill_req && !mem_valid) begin
            mem_dat   = (refill_adr + 32'(4 * word_cnt)) ^ 32'hA5A5_0000;
            mem_valid = 1'b1;
            word_cnt++;
         end else begin
            mem_valid = 1'b0;
            if (!refill_req) begin
               word_cnt = 0;
            end
         end
      end
   end

   // Limit covers every golden entry plus reset and tag clear
   initial begin : watchdog
      cycle_cnt = 0;
      wait (cycle_limit > 0);
      while (cycle_cnt < cycle_limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      abort_run($sformatf("Timeout after %0d cycles without finishing", cycle_cnt));
   end

   initial begin
      rst           = 1'b1;
      cpu_req_valid = 1'b0;
      cpu_req       = '0;
      inv           = 1'b0;
      inv_idx       = '0;
      cycle_limit   = 0;
      load_golden();
      cycle_limit = CYCLES_PER_OP * ops.size() + RESET_CYCLES + (1 << `DC_SET_W);
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;
      // Requests wait in IDLE until the tag clear ends
      foreach (ops[i]) begin
         case (ops[i].code)
            "R", "W": run_request(ops[i], i);
            "I": run_invalidate(ops[i], i);
            default: abort_run($sformatf("Unknown opcode in golden entry %0d", i));
         endcase
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== verification/dcache_golden.txt ====
# op addr/set wdata bsel expected_rdata refill_expected (all hex)
# R read, W write, I invalidate set given in the address column
R 00000104 00000000 0 A5A50104 1
R 0000011C 00000000 0 A5A5011C 0
R 00000100 00000000 0 A5A50100 0
W 00000108 11223344 5 00000000 0
R 00000108 00000000 0 A5220144 0
W 00000110 DEADBEEF F 00000000 0
R 00000110 00000000 0 DEADBEEF 0
W 00004200 CAFEF00D F 00000000 0
R 00004200 00000000 0 A5A54200 1
R 00001060 00000000 0 A5A51060 1
R 00001864 00000000 0 A5A51864 1
W 00001864 000000AA 1 00000000 0
R 00001864 00000000 0 A5A518AA 0
R 00001068 00000000 0 A5A51068 0
R 00002060 00000000 0 A5A52060 1
R 0000107C 00000000 0 A5A5107C 0
R 00001864 00000000 0 A5A51864 1
I 00000008 00000000 0 00000000 0
R 00000108 00000000 0 A5A50108 1
R 00000110 00000000 0 A5A50110 0
I 00000003 00000000 0 00000000 0
R 0000107C 00000000 0 A5A5107C 1

// ==== verilog.f ====
+incdir+common
common/dcache_pkg.sv
hdl/dc_tag_store.sv
hdl/dc_way_store.sv
hdl/dcache_ctrl.sv
hdl/dcache_top.sv
verification/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - common

sources:
  - files:
      - common/dcache_pkg.sv
      - hdl/dc_tag_store.sv
      - hdl/dc_way_store.sv
      - hdl/dcache_ctrl.sv
      - hdl/dcache_top.sv
  - target: test
    files:
      - verification/dcache_tb.sv
